//--- rvv_arch_pkg.sv
package rvv_arch_pkg;

  // vector register geometry
  localparam int VLEN        = 128;
  localparam int BYTE_WIDTH  = 8;
  localparam int HWORD_WIDTH = 16;
  localparam int WORD_WIDTH  = 32;
  localparam int VLENB       = VLEN / BYTE_WIDTH;

  // element counts per register
  localparam int NUM_HWORDS = VLEN / HWORD_WIDTH;
  localparam int NUM_WORDS  = VLEN / WORD_WIDTH;

  // scalar side
  localparam int XLEN = 32;

  // bookkeeping fields
  localparam int ROB_DEPTH_WIDTH = 3;
  localparam int UOP_INDEX_WIDTH = 3;

  typedef logic [VLEN-1:0]            vreg_t;
  typedef logic [VLENB-1:0]           vmask_t;
  typedef logic [XLEN-1:0]            xreg_t;
  typedef logic [ROB_DEPTH_WIDTH-1:0] rob_idx_t;
  typedef logic [UOP_INDEX_WIDTH-1:0] uop_idx_t;

  // one element at each supported width
  typedef logic [BYTE_WIDTH-1:0]  byte_t;
  typedef logic [HWORD_WIDTH-1:0] hword_t;
  typedef logic [WORD_WIDTH-1:0]  word_t;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

endpackage

//--- rvv_uop_pkg.sv
package rvv_uop_pkg;

  import rvv_arch_pkg::*;

  // operand form, from the instruction funct3 field
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  typedef enum logic [5:0] {
    VMINU      = 6'b000100,
    VMIN       = 6'b000101,
    VMAXU      = 6'b000110,
    VMAX       = 6'b000111,
    VXUNARY0   = 6'b010010,
    VMERGE_VMV = 6'b010111
  } funct6_e;

  // vs1 field selects the extension under VXUNARY0
  typedef enum logic [4:0] {
    VZEXT_VF4 = 5'b00100,
    VSEXT_VF4 = 5'b00101,
    VZEXT_VF2 = 5'b00110,
    VSEXT_VF2 = 5'b00111
  } vxunary_e;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_MIN,
    OP_MAX,
    OP_MOVE,
    OP_MERGE,
    OP_EXTEND
  } alu_op_e;

  typedef struct packed {
    rob_idx_t rob_entry;
    funct6_e  funct6;
    funct3_e  funct3;
    logic     vm;
    vxunary_e vs1;
    vreg_t    vs1_data;
    logic     vs1_data_valid;
    vreg_t    vs2_data;
    logic     vs2_data_valid;
    xreg_t    rs1_data;
    logic     rs1_data_valid;
    vreg_t    v0_data;
    logic     v0_data_valid;
    eew_e     vd_eew;
    eew_e     vs2_eew;
    uop_idx_t uop_index;
  } alu_uop_t;

  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    logic     is_signed;
    eew_e     eew;
    logic     ext_quarter;
    vreg_t    src1;
    vreg_t    src2;
    vmask_t   v0;
    rob_idx_t rob_entry;
  } alu_operands_t;

  typedef struct packed {
    rob_idx_t rob_entry;
    vreg_t    w_data;
    logic     ignore_vma;
  } alu_result_t;

endpackage

//--- rvv_alu_operand_prep.sv
`timescale 1ns/1ps

module rvv_alu_operand_prep (
  input  logic                       alu_uop_valid,
  input  rvv_uop_pkg::alu_uop_t      alu_uop,
  output rvv_uop_pkg::alu_operands_t operands
);

  import rvv_arch_pkg::*;
  import rvv_uop_pkg::*;

  alu_op_e     dec_op;
  logic        dec_signed;
  logic        dec_quarter;
  logic        srcs_ready;
  logic        src1_ready;
  logic        op_valid;
  eew_e        sel_eew;
  int unsigned mask_step;
  vreg_t       scalar_rep;
  vreg_t       ext_src;
  vmask_t      v0_slice;

  // vector form reads vs1, scalar and immediate forms read rs1
  assign src1_ready = (alu_uop.funct3 == OPIVV) ? alu_uop.vs1_data_valid
                                                : alu_uop.rs1_data_valid;

  always_comb begin
    dec_op      = OP_NONE;
    dec_signed  = 1'b0;
    dec_quarter = 1'b0;
    srcs_ready  = 1'b0;
    case (alu_uop.funct3)
      OPIVV, OPIVX, OPIVI: begin
        case (alu_uop.funct6)
          VMINU, VMIN, VMAXU, VMAX: begin
            // no immediate form for min/max
            if (alu_uop.funct3 != OPIVI) begin
              dec_op     = (alu_uop.funct6 == VMINU || alu_uop.funct6 == VMIN) ? OP_MIN : OP_MAX;
              dec_signed = (alu_uop.funct6 == VMIN || alu_uop.funct6 == VMAX);
              srcs_ready = src1_ready & alu_uop.vs2_data_valid;
            end
          end
          VMERGE_VMV: begin
            if (alu_uop.vm) begin
              dec_op     = OP_MOVE;
              srcs_ready = src1_ready;
            end else begin
              dec_op     = OP_MERGE;
              srcs_ready = src1_ready & alu_uop.vs2_data_valid & alu_uop.v0_data_valid;
            end
          end
          default: ;
        endcase
      end
      OPMVV: begin
        if (alu_uop.funct6 == VXUNARY0) begin
          case (alu_uop.vs1)
            VZEXT_VF2, VSEXT_VF2: begin
              if (alu_uop.vs2_eew == EEW8 || alu_uop.vs2_eew == EEW16) begin
                dec_op     = OP_EXTEND;
                dec_signed = (alu_uop.vs1 == VSEXT_VF2);
                srcs_ready = !alu_uop.vs1_data_valid & alu_uop.vs2_data_valid;
              end
            end
            VZEXT_VF4, VSEXT_VF4: begin
              if (alu_uop.vs2_eew == EEW8) begin
                dec_op      = OP_EXTEND;
                dec_signed  = (alu_uop.vs1 == VSEXT_VF4);
                dec_quarter = 1'b1;
                srcs_ready  = !alu_uop.vs1_data_valid & alu_uop.vs2_data_valid;
              end
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

  assign op_valid = alu_uop_valid & srcs_ready;

  // vmv writes at the destination width
  assign sel_eew = (dec_op == OP_MOVE) ? alu_uop.vd_eew : alu_uop.vs2_eew;

  always_comb begin
    case (sel_eew)
      EEW8: begin
        scalar_rep = {VLENB{alu_uop.rs1_data[BYTE_WIDTH-1:0]}};
        mask_step  = VLEN / BYTE_WIDTH;
      end
      EEW16: begin
        scalar_rep = {NUM_HWORDS{alu_uop.rs1_data[HWORD_WIDTH-1:0]}};
        mask_step  = VLEN / HWORD_WIDTH;
      end
      default: begin
        scalar_rep = {NUM_WORDS{alu_uop.rs1_data[WORD_WIDTH-1:0]}};
        mask_step  = VLEN / WORD_WIDTH;
      end
    endcase
  end

  // one mask bit per element, elements per uop depend on eew
  assign v0_slice = alu_uop.v0_data[alu_uop.uop_index * mask_step +: VLENB];

  // selected half or quarter of vs2, copied across the register
  assign ext_src = dec_quarter
    ? {4{alu_uop.vs2_data[alu_uop.uop_index[1:0] * (VLEN / 4) +: VLEN / 4]}}
    : {2{alu_uop.vs2_data[alu_uop.uop_index[0] * (VLEN / 2) +: VLEN / 2]}};

  always_comb begin
    operands.valid       = op_valid;
    operands.op          = op_valid ? dec_op : OP_NONE;
    operands.is_signed   = dec_signed;
    operands.eew         = sel_eew;
    operands.ext_quarter = dec_quarter;
    operands.src1        = (alu_uop.funct3 == OPIVV) ? alu_uop.vs1_data : scalar_rep;
    operands.src2        = (dec_op == OP_EXTEND) ? ext_src : alu_uop.vs2_data;
    operands.v0          = v0_slice;
    operands.rob_entry   = alu_uop.rob_entry;
  end

  always_comb begin
    if (operands.valid && operands.op == OP_MERGE) begin
      assert (alu_uop.uop_index * mask_step + VLENB <= VLEN)
        else $error("mask slice for uop_index %0d leaves v0", alu_uop.uop_index);
    end
    if (operands.valid && operands.op == OP_EXTEND) begin
      assert (operands.eew != EEW32)
        else $error("extension decoded with a 32-bit source");
    end
  end

endmodule

//--- rvv_alu_minmax.sv
`timescale 1ns/1ps

module rvv_alu_minmax (
  input  rvv_uop_pkg::alu_operands_t operands,
  output rvv_arch_pkg::vreg_t        minmax
);

  import rvv_arch_pkg::*;
  import rvv_uop_pkg::*;

  logic                      take_max;
  logic                      sgn;
  byte_t  [VLENB-1:0]        src1_b;
  byte_t  [VLENB-1:0]        src2_b;
  hword_t [NUM_HWORDS-1:0]   src1_h;
  hword_t [NUM_HWORDS-1:0]   src2_h;
  word_t  [NUM_WORDS-1:0]    src1_w;
  word_t  [NUM_WORDS-1:0]    src2_w;
  byte_t  [VLENB-1:0]        res_b;
  hword_t [NUM_HWORDS-1:0]   res_h;
  word_t  [NUM_WORDS-1:0]    res_w;

  // operands arrive widened to WORD_WIDTH+1, so one compare serves every eew
  function automatic word_t pick_lane(input logic signed [WORD_WIDTH:0] a,
                                      input logic signed [WORD_WIDTH:0] b,
                                      input logic                       want_max);
    logic a_lt_b;
    a_lt_b = a < b;
    return (a_lt_b ^ want_max) ? a[WORD_WIDTH-1:0] : b[WORD_WIDTH-1:0];
  endfunction

  assign take_max = (operands.op == OP_MAX);
  assign sgn      = operands.is_signed;

  assign src1_b = operands.src1;
  assign src2_b = operands.src2;
  assign src1_h = operands.src1;
  assign src2_h = operands.src2;
  assign src1_w = operands.src1;
  assign src2_w = operands.src2;

  for (genvar i = 0; i < VLENB; i++) begin : g_byte
    assign res_b[i] = byte_t'(pick_lane(
      {{(WORD_WIDTH + 1 - BYTE_WIDTH){sgn & src2_b[i][BYTE_WIDTH-1]}}, src2_b[i]},
      {{(WORD_WIDTH + 1 - BYTE_WIDTH){sgn & src1_b[i][BYTE_WIDTH-1]}}, src1_b[i]},
      take_max));
  end

  for (genvar i = 0; i < NUM_HWORDS; i++) begin : g_hword
    assign res_h[i] = hword_t'(pick_lane(
      {{(WORD_WIDTH + 1 - HWORD_WIDTH){sgn & src2_h[i][HWORD_WIDTH-1]}}, src2_h[i]},
      {{(WORD_WIDTH + 1 - HWORD_WIDTH){sgn & src1_h[i][HWORD_WIDTH-1]}}, src1_h[i]},
      take_max));
  end

  for (genvar i = 0; i < NUM_WORDS; i++) begin : g_word
    assign res_w[i] = pick_lane({sgn & src2_w[i][WORD_WIDTH-1], src2_w[i]},
                                {sgn & src1_w[i][WORD_WIDTH-1], src1_w[i]},
                                take_max);
  end

  always_comb begin
    case (operands.eew)
      EEW8:    minmax = res_b;
      EEW16:   minmax = res_h;
      default: minmax = res_w;
    endcase
  end

endmodule

//--- rvv_alu_extend.sv
`timescale 1ns/1ps

module rvv_alu_extend (
  input  rvv_uop_pkg::alu_operands_t operands,
  output rvv_arch_pkg::vreg_t        extended
);

  import rvv_arch_pkg::*;

  logic                    sgn;
  byte_t  [VLENB-1:0]      src_b;
  hword_t [NUM_HWORDS-1:0] src_h;
  hword_t [NUM_HWORDS-1:0] ext_b2h;
  word_t  [NUM_WORDS-1:0]  ext_h2w;
  word_t  [NUM_WORDS-1:0]  ext_b2w;

  assign sgn   = operands.is_signed;
  assign src_b = operands.src2;
  assign src_h = operands.src2;

  // only the low elements are read, the upper copies repeat them
  for (genvar i = 0; i < NUM_HWORDS; i++) begin : g_b2h
    assign ext_b2h[i] = {{(HWORD_WIDTH - BYTE_WIDTH){sgn & src_b[i][BYTE_WIDTH-1]}},
                         src_b[i]};
  end

  for (genvar i = 0; i < NUM_WORDS; i++) begin : g_to_word
    assign ext_h2w[i] = {{(WORD_WIDTH - HWORD_WIDTH){sgn & src_h[i][HWORD_WIDTH-1]}},
                         src_h[i]};
    assign ext_b2w[i] = {{(WORD_WIDTH - BYTE_WIDTH){sgn & src_b[i][BYTE_WIDTH-1]}},
                         src_b[i]};
  end

  always_comb begin
    if (operands.ext_quarter) begin
      // factor 4, 8 to 32
      extended = ext_b2w;
    end else if (operands.eew == EEW16) begin
      extended = ext_h2w;
    end else begin
      extended = ext_b2h;
    end
  end

endmodule

//--- rvv_alu_result_stage.sv
`timescale 1ns/1ps

module rvv_alu_result_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  rvv_uop_pkg::alu_operands_t operands,
  input  rvv_arch_pkg::vreg_t        minmax,
  input  rvv_arch_pkg::vreg_t        extended,
  output logic                       result_valid,
  output rvv_uop_pkg::alu_result_t   result
);

  import rvv_arch_pkg::*;
  import rvv_uop_pkg::*;

  byte_t  [VLENB-1:0]      src1_b;
  byte_t  [VLENB-1:0]      src2_b;
  hword_t [NUM_HWORDS-1:0] src1_h;
  hword_t [NUM_HWORDS-1:0] src2_h;
  word_t  [NUM_WORDS-1:0]  src1_w;
  word_t  [NUM_WORDS-1:0]  src2_w;
  byte_t  [VLENB-1:0]      merge_b;
  hword_t [NUM_HWORDS-1:0] merge_h;
  word_t  [NUM_WORDS-1:0]  merge_w;
  vreg_t                   merged;
  alu_result_t             result_next;

  assign src1_b = operands.src1;
  assign src2_b = operands.src2;
  assign src1_h = operands.src1;
  assign src2_h = operands.src2;
  assign src1_w = operands.src1;
  assign src2_w = operands.src2;

  // mask bit 1 takes src1, bit 0 keeps src2
  for (genvar i = 0; i < VLENB; i++) begin : g_merge_b
    assign merge_b[i] = operands.v0[i] ? src1_b[i] : src2_b[i];
  end

  for (genvar i = 0; i < NUM_HWORDS; i++) begin : g_merge_h
    assign merge_h[i] = operands.v0[i] ? src1_h[i] : src2_h[i];
  end

  for (genvar i = 0; i < NUM_WORDS; i++) begin : g_merge_w
    assign merge_w[i] = operands.v0[i] ? src1_w[i] : src2_w[i];
  end

  always_comb begin
    case (operands.eew)
      EEW8:    merged = merge_b;
      EEW16:   merged = merge_h;
      default: merged = merge_w;
    endcase
  end

  always_comb begin
    result_next.rob_entry  = operands.rob_entry;
    result_next.ignore_vma = (operands.op == OP_MERGE);
    case (operands.op)
      OP_MIN, OP_MAX: result_next.w_data = minmax;
      OP_MOVE:        result_next.w_data = operands.src1;
      OP_MERGE:       result_next.w_data = merged;
      OP_EXTEND:      result_next.w_data = extended;
      default:        result_next.w_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= operands.valid;
      if (operands.valid) begin
        result <= result_next;
      end
    end
  end

  a_idle_after_rst: assert property (@(posedge clk) rst |=> !result_valid)
    else $error("result_valid high right after reset");

endmodule

//--- rvv_alu_other.sv
`timescale 1ns/1ps

module rvv_alu_other (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alu_uop_valid,
  input  rvv_uop_pkg::alu_uop_t    alu_uop,
  output logic                     result_valid,
  output rvv_uop_pkg::alu_result_t result
);

  import rvv_arch_pkg::*;
  import rvv_uop_pkg::*;

  alu_operands_t operands;
  vreg_t         minmax;
  vreg_t         extended;

  // decode and operand steering, combinational
  rvv_alu_operand_prep prep_i (
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop),
    .operands      (operands)
  );

  rvv_alu_minmax minmax_i (
    .operands (operands),
    .minmax   (minmax)
  );

  rvv_alu_extend extend_i (
    .operands (operands),
    .extended (extended)
  );

  // the only register in the unit
  rvv_alu_result_stage result_i (
    .clk          (clk),
    .rst          (rst),
    .operands     (operands),
    .minmax       (minmax),
    .extended     (extended),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

//--- tb_rvv_alu_other.sv
`timescale 1ns/1ps

module tb_rvv_alu_other;

  import rvv_arch_pkg::*;
  import rvv_uop_pkg::*;

  // the tests take about 120 cycles
  localparam int TIMEOUT_CYCLES = 200;

  logic        clk = 1'b0;
  logic        rst;
  logic        alu_uop_valid;
  alu_uop_t    alu_uop;
  logic        result_valid;
  alu_result_t result;

  integer      seed = 20875;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  string       cur_test = "startup";
  rob_idx_t    rob_ctr = '0;
  alu_result_t exp_q[$];
  int          due_q[$];

  eew_e        eews[3] = '{EEW8, EEW16, EEW32};
  funct6_e     mm_ops[4] = '{VMINU, VMIN, VMAXU, VMAX};

  rvv_alu_other dut_i (
    .clk           (clk),
    .rst           (rst),
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop),
    .result_valid  (result_valid),
    .result        (result)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles in test %s, %0d results never arrived",
               cycles, cur_test, exp_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_vreg(input string what, input vreg_t exp, input vreg_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_rob(input string what, input rob_idx_t exp, input rob_idx_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  // results are compared mid-cycle, in issue order, one cycle after issue
  always @(negedge clk) begin : monitor
    alu_result_t want;
    int          due;
    if (rst === 1'b0 && result_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: result_valid went high with no micro-op pending", cur_test);
      end else begin
        want = exp_q.pop_front();
        due  = due_q.pop_front();
        checks++;
        if (cycles != due) begin
          errors++;
          $display("error: %s latency: expected cycle %0d, actual cycle %0d",
                   cur_test, due, cycles);
        end
        check_rob("rob_entry", want.rob_entry, result.rob_entry);
        check_vreg("w_data", want.w_data, result.w_data);
        check_flag("ignore_vma", want.ignore_vma, result.ignore_vma);
      end
    end
  end

  function automatic int elem_width(input eew_e e);
    case (e)
      EEW8:    return BYTE_WIDTH;
      EEW16:   return HWORD_WIDTH;
      default: return WORD_WIDTH;
    endcase
  endfunction

  function automatic longint get_elem(input vreg_t v, input int w, input int i, input bit sgn);
    longint r;
    r = longint'((v >> (i * w)) & ((vreg_t'(1) << w) - 1));
    if (sgn && r[w-1]) begin
      r = r - (longint'(1) << w);
    end
    return r;
  endfunction

  function automatic vreg_t put_elem(input vreg_t v, input int w, input int i, input longint val);
    vreg_t m;
    m = ((vreg_t'(1) << w) - 1) << (i * w);
    return (v & ~m) | ((vreg_t'(val) << (i * w)) & m);
  endfunction

  // vs2 against src1, element by element
  function automatic vreg_t model_minmax(input vreg_t vs2, input vreg_t src1, input int w,
                                         input bit sgn, input bit take_max);
    vreg_t  r;
    longint x;
    longint y;
    r = '0;
    for (int i = 0; i < VLEN / w; i++) begin
      x = get_elem(vs2, w, i, sgn);
      y = get_elem(src1, w, i, sgn);
      if (take_max) begin
        r = put_elem(r, w, i, (x > y) ? x : y);
      end else begin
        r = put_elem(r, w, i, (x < y) ? x : y);
      end
    end
    return r;
  endfunction

  function automatic vreg_t model_replicate(input xreg_t s, input int w);
    vreg_t r;
    r = '0;
    for (int i = 0; i < VLEN / w; i++) begin
      r = put_elem(r, w, i, longint'(s));
    end
    return r;
  endfunction

  function automatic vreg_t model_merge(input vreg_t src1, input vreg_t vs2, input vreg_t v0,
                                        input int w, input int idx);
    vreg_t r;
    r = '0;
    for (int i = 0; i < VLEN / w; i++) begin
      r = put_elem(r, w, i, v0[idx * (VLEN / w) + i] ? get_elem(src1, w, i, 1'b0)
                                                      : get_elem(vs2, w, i, 1'b0));
    end
    return r;
  endfunction

  function automatic vreg_t model_extend(input vreg_t vs2, input int w, input int factor,
                                         input int part, input bit sgn);
    vreg_t r;
    int    n;
    r = '0;
    n = VLEN / (w * factor);
    for (int i = 0; i < n; i++) begin
      r = put_elem(r, w * factor, i, get_elem(vs2, w, part * n + i, sgn));
    end
    return r;
  endfunction

  function automatic vreg_t rand_vreg();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // all source valids low, caller sets the ones it needs
  function automatic alu_uop_t base_uop(input funct6_e f6, input funct3_e f3, input logic vm,
                                        input eew_e e);
    alu_uop_t u;
    u          = '0;
    u.funct6   = f6;
    u.funct3   = f3;
    u.vm       = vm;
    u.vd_eew   = e;
    u.vs2_eew  = e;
    u.vs1_data = rand_vreg();
    u.vs2_data = rand_vreg();
    u.v0_data  = rand_vreg();
    u.rs1_data = $random(seed);
    return u;
  endfunction

  task automatic issue(input alu_uop_t u, input vreg_t data, input logic ign);
    alu_result_t want;
    u.rob_entry     = rob_ctr;
    want.rob_entry  = rob_ctr;
    want.w_data     = data;
    want.ignore_vma = ign;
    exp_q.push_back(want);
    due_q.push_back(cycles + 1);
    rob_ctr++;
    alu_uop       = u;
    alu_uop_valid = 1'b1;
    @(posedge clk);
    #1;
  endtask

  task automatic drive_without_result(input alu_uop_t u, input logic v);
    alu_uop       = u;
    alu_uop_valid = v;
    @(posedge clk);
    #1;
  endtask

  // two quiet cycles let the monitor catch stray results
  task automatic drain();
    alu_uop_valid = 1'b0;
    while (exp_q.size() > 0) begin
      @(posedge clk);
      #1;
    end
    repeat (2) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test(input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: done, no errors", cur_test);
    end else begin
      $display("test %s: done, %0d errors", cur_test, errors - err_before);
    end
  endtask

  task automatic test_reset_idle();
    alu_uop_t u;
    int       e0;
    cur_test = "reset_idle";
    e0       = errors;
    @(negedge clk);
    check_flag("result_valid after reset", 1'b0, result_valid);
    check_vreg("w_data after reset", '0, result.w_data);
    @(posedge clk);
    #1;
    u = base_uop(VMAX, OPIVV, 1'b1, EEW8);
    u.vs1_data_valid = 1'b1;
    u.vs2_data_valid = 1'b1;
    drive_without_result(u, 1'b0);
    drain();
    finish_test(e0);
  endtask

  // back to back, one uop per cycle
  task automatic test_minmax_vv();
    alu_uop_t u;
    int       e0;
    int       w;
    bit       sgn;
    bit       mx;
    cur_test = "minmax_vv";
    e0       = errors;
    for (int j = 0; j < 3; j++) begin
      for (int k = 0; k < 4; k++) begin
        w   = elem_width(eews[j]);
        sgn = (mm_ops[k] == VMIN || mm_ops[k] == VMAX);
        mx  = (mm_ops[k] == VMAXU || mm_ops[k] == VMAX);
        u   = base_uop(mm_ops[k], OPIVV, 1'b1, eews[j]);
        u.vs1_data_valid = 1'b1;
        u.vs2_data_valid = 1'b1;
        issue(u, model_minmax(u.vs2_data, u.vs1_data, w, sgn, mx), 1'b0);
      end
    end
    drain();
    finish_test(e0);
  endtask

  task automatic test_scalar_forms();
    alu_uop_t   u;
    int         e0;
    int         w;
    bit         sgn;
    bit         mx;
    logic [4:0] imm;
    cur_test = "scalar_forms";
    e0       = errors;
    for (int j = 0; j < 3; j++) begin
      w = elem_width(eews[j]);
      for (int k = 0; k < 4; k++) begin
        sgn = (mm_ops[k] == VMIN || mm_ops[k] == VMAX);
        mx  = (mm_ops[k] == VMAXU || mm_ops[k] == VMAX);
        u   = base_uop(mm_ops[k], OPIVX, 1'b1, eews[j]);
        u.rs1_data_valid = 1'b1;
        u.vs2_data_valid = 1'b1;
        issue(u, model_minmax(u.vs2_data, model_replicate(u.rs1_data, w), w, sgn, mx), 1'b0);
      end
      // vmv replicates at vd_eew, vs2_eew deliberately differs
      u = base_uop(VMERGE_VMV, OPIVX, 1'b1, eews[j]);
      u.vs2_eew        = eews[(j + 1) % 3];
      u.rs1_data_valid = 1'b1;
      issue(u, model_replicate(u.rs1_data, w), 1'b0);
      imm = $random(seed);
      u   = base_uop(VMERGE_VMV, OPIVI, 1'b1, eews[j]);
      u.vs2_eew        = eews[(j + 2) % 3];
      u.rs1_data       = {{(XLEN - 5){imm[4]}}, imm};
      u.rs1_data_valid = 1'b1;
      issue(u, model_replicate(u.rs1_data, w), 1'b0);
    end
    drain();
    finish_test(e0);
  endtask

  task automatic test_merge();
    alu_uop_t u;
    int       e0;
    int       w;
    cur_test = "merge";
    e0       = errors;
    for (int j = 0; j < 3; j++) begin
      w = elem_width(eews[j]);
      for (int idx = 0; idx < 4; idx++) begin
        u = base_uop(VMERGE_VMV, OPIVV, 1'b0, eews[j]);
        u.vs1_data_valid = 1'b1;
        u.vs2_data_valid = 1'b1;
        u.v0_data_valid  = 1'b1;
        u.uop_index      = uop_idx_t'(idx);
        issue(u, model_merge(u.vs1_data, u.vs2_data, u.v0_data, w, idx), 1'b1);
      end
    end
    // plain vmv.v.v
    u = base_uop(VMERGE_VMV, OPIVV, 1'b1, EEW16);
    u.vs1_data_valid = 1'b1;
    issue(u, u.vs1_data, 1'b0);
    drain();
    finish_test(e0);
  endtask

  task automatic test_extend();
    alu_uop_t u;
    int       e0;
    vxunary_e f2_ops[2] = '{VZEXT_VF2, VSEXT_VF2};
    vxunary_e f4_ops[2] = '{VZEXT_VF4, VSEXT_VF4};
    cur_test = "extend";
    e0       = errors;
    for (int s = 0; s < 2; s++) begin
      for (int j = 0; j < 2; j++) begin
        for (int part = 0; part < 2; part++) begin
          u = base_uop(VXUNARY0, OPMVV, 1'b1, eews[j]);
          u.vs1            = f2_ops[s];
          u.vd_eew         = eews[j + 1];
          u.vs2_data_valid = 1'b1;
          u.uop_index      = uop_idx_t'(part);
          issue(u, model_extend(u.vs2_data, elem_width(eews[j]), 2, part, s), 1'b0);
        end
      end
      for (int part = 0; part < 4; part++) begin
        u = base_uop(VXUNARY0, OPMVV, 1'b1, EEW8);
        u.vs1            = f4_ops[s];
        u.vd_eew         = EEW32;
        u.vs2_data_valid = 1'b1;
        u.uop_index      = uop_idx_t'(part);
        issue(u, model_extend(u.vs2_data, BYTE_WIDTH, 4, part, s), 1'b0);
      end
    end
    drain();
    finish_test(e0);
  endtask

  task automatic test_missing_source();
    alu_uop_t u;
    int       e0;
    cur_test = "missing_source";
    e0       = errors;
    u = base_uop(VMERGE_VMV, OPIVV, 1'b0, EEW8);
    u.vs1_data_valid = 1'b1;
    u.vs2_data_valid = 1'b1;
    drive_without_result(u, 1'b1);
    u = base_uop(VMIN, OPIVX, 1'b1, EEW16);
    u.rs1_data_valid = 1'b1;
    drive_without_result(u, 1'b1);
    // extension with vs1 data marked valid
    u = base_uop(VXUNARY0, OPMVV, 1'b1, EEW8);
    u.vs1            = VZEXT_VF2;
    u.vs1_data_valid = 1'b1;
    u.vs2_data_valid = 1'b1;
    drive_without_result(u, 1'b1);
    // factor 4 from 16 bits is not a legal width
    u = base_uop(VXUNARY0, OPMVV, 1'b1, EEW16);
    u.vs1            = VSEXT_VF4;
    u.vs2_data_valid = 1'b1;
    drive_without_result(u, 1'b1);
    drain();
    finish_test(e0);
  endtask

  initial begin
    rst           = 1'b1;
    alu_uop_valid = 1'b0;
    alu_uop       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_idle();
    test_minmax_vv();
    test_scalar_forms();
    test_merge();
    test_extend();
    test_missing_source();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
rvv_arch_pkg.sv
rvv_uop_pkg.sv
rvv_alu_operand_prep.sv
rvv_alu_minmax.sv
rvv_alu_extend.sv
rvv_alu_result_stage.sv
rvv_alu_other.sv
tb_rvv_alu_other.sv

//--- Bender.yml
package:
  name: rvv_alu_other

sources:
  # packages first, the modules import them
  - rvv_arch_pkg.sv
  - rvv_uop_pkg.sv
  - rvv_alu_operand_prep.sv
  - rvv_alu_minmax.sv
  - rvv_alu_extend.sv
  - rvv_alu_result_stage.sv
  - rvv_alu_other.sv
  - target: test
    files:
      - tb_rvv_alu_other.sv
